//--- source/spiSensor_consts.svh
// project constants; the bank index width must cover SAMPLE_COUNT and opcodes are 8 bits
`ifndef SPI_SENSOR_CONSTS_SVH
`define SPI_SENSOR_CONSTS_SVH

// opcodes, first byte of a frame
`define SPI_CMD_READ  8'h0B
`define SPI_CMD_WRITE 8'h0A

// sample bank geometry
// index width of 3 leaves codes 5..7 unused
`define SAMPLE_COUNT 5
`define SAMPLE_IDX_W 3

// reset contents of the bank
// these are the reference sensor readings
`define SAMPLE_INIT_0 8'hFF
`define SAMPLE_INIT_1 8'h06
`define SAMPLE_INIT_2 8'hFD
`define SAMPLE_INIT_3 8'h02
`define SAMPLE_INIT_4 8'h24

// an address at or above SAMPLE_COUNT selects entry 0
// a data byte past the last entry wraps to entry 0

`endif

//--- source/spiSensorPkg.sv
// shared types only; the byte width is fixed at 8 by the SPI protocol and is not a parameter
package spiSensorPkg;

    // one byte on the wire or in the sample bank
    typedef logic [7:0] spiByte_t;

    // position inside a frame
    // phaseCmd    first byte, holds the opcode
    // phaseAddr   second byte, start index into the bank
    // phaseData   every byte after the address
    // phaseIgnore unknown opcode, rest of frame is dropped
    typedef enum logic [1:0] {
        phaseCmd    = 2'd0,
        phaseAddr   = 2'd1,
        phaseData   = 2'd2,
        phaseIgnore = 2'd3
    } framePhase_e;

    // a frame always starts in phaseCmd when chip select falls
    // and only leaves phaseIgnore when chip select rises again

endpackage : spiSensorPkg

//--- source/spiRxShifter.sv
// mode 0 style sampling on the rising SPI clock edge; chip select high clears the bit count
`timescale 1ns/1ps

module spiRxShifter (
    input  logic                  i_SPI_Clk,
    input  logic                  reset,
    input  logic                  i_SPI_CSLow,
    input  logic                  i_SPI_Mosi,
    output spiSensorPkg::spiByte_t o_RxByteNext,
    output logic                  o_RxByteDone,
    output spiSensorPkg::spiByte_t o_LastByte
);

    // seven bits already taken for the current byte
    logic [6:0] shiftReg;
    // bit position inside the byte, 7 means the last bit is on MOSI now
    logic [2:0] bitCnt;
    // chip select high acts like a frame reset
    logic       asyncClear;

    assign asyncClear = reset | i_SPI_CSLow;

    // byte including the bit being sampled on this edge
    assign o_RxByteNext = {shiftReg, i_SPI_Mosi};

    // combinational, high in the cycle whose rising edge takes bit 7
    assign o_RxByteDone = (bitCnt == 3'd7);

    // shift MSB first and count bits
    always_ff @(posedge i_SPI_Clk or posedge asyncClear) begin
        if (asyncClear) begin
            shiftReg <= '0;
            bitCnt   <= '0;
        end else begin
            shiftReg <= o_RxByteNext[6:0];
            bitCnt   <= bitCnt + 3'd1;
        end
    end

    // last complete byte, held across chip select rise for the top-level latch
    // a partial byte never reaches this register
    always_ff @(posedge i_SPI_Clk or posedge reset) begin
        if (reset) begin
            o_LastByte <= '0;
        end else if (o_RxByteDone) begin
            o_LastByte <= o_RxByteNext;
        end
    end

    // MOSI must carry a real bit on every edge of a frame
    mosiKnown : assert property (
        @(posedge i_SPI_Clk) disable iff (reset || i_SPI_CSLow)
        !$isunknown(i_SPI_Mosi)
    ) else $error("MOSI is unknown inside a frame");

endmodule : spiRxShifter

//--- source/frameDecoder.sv
// opcodes other than read/write ignore the rest of the frame; bank index is clamped to range
`timescale 1ns/1ps
`include "spiSensor_consts.svh"

module frameDecoder (
    input  logic                      i_SPI_Clk,
    input  logic                      reset,
    input  logic                      i_SPI_CSLow,
    input  spiSensorPkg::spiByte_t     i_RxByte,
    input  logic                      i_RxByteDone,
    input  spiSensorPkg::spiByte_t     i_BankRdData,
    output logic [`SAMPLE_IDX_W-1:0]  o_BankIdx,
    output logic                      o_BankWrEn,
    output spiSensorPkg::spiByte_t     o_BankWrData,
    output logic                      o_TxLoad,
    output spiSensorPkg::spiByte_t     o_TxByte
);

    spiSensorPkg::framePhase_e phase;
    // mode latched at the end of the command byte
    logic                      isRead;
    logic                      isWrite;
    // index of the entry served by the current data byte
    logic [`SAMPLE_IDX_W-1:0]  idx;
    // candidate indices
    logic [`SAMPLE_IDX_W-1:0]  addrIdx;
    logic [`SAMPLE_IDX_W-1:0]  stepIdx;
    logic [`SAMPLE_IDX_W-1:0]  nextIdx;
    logic                      cmdRead;
    logic                      cmdWrite;
    logic                      writing;
    logic                      replyEn;
    logic                      asyncClear;

    assign asyncClear = reset | i_SPI_CSLow;

    // opcode decode on the byte being completed
    assign cmdRead  = (i_RxByte == `SPI_CMD_READ);
    assign cmdWrite = (i_RxByte == `SPI_CMD_WRITE);

    // out-of-range address falls back to entry 0
    assign addrIdx = (i_RxByte < spiSensorPkg::spiByte_t'(`SAMPLE_COUNT)) ?
                     i_RxByte[`SAMPLE_IDX_W-1:0] : '0;

    // step with wrap from the last entry
    assign stepIdx = (idx == `SAMPLE_IDX_W'(`SAMPLE_COUNT - 1)) ? '0 : idx + 1'b1;

    // address byte sets the start, data bytes step
    assign nextIdx = (phase == spiSensorPkg::phaseAddr) ? addrIdx : stepIdx;

    // write frames point the bank at the current entry, read frames at the next one
    assign writing   = isWrite && (phase == spiSensorPkg::phaseData);
    assign o_BankIdx = writing ? idx : nextIdx;

    // store each completed data byte of a write frame
    assign o_BankWrEn   = i_RxByteDone && writing;
    assign o_BankWrData = i_RxByte;

    // reply is the bank entry only once the address is known in a read frame
    assign replyEn  = isRead && ((phase == spiSensorPkg::phaseAddr) ||
                                 (phase == spiSensorPkg::phaseData));
    assign o_TxLoad = i_RxByteDone;
    assign o_TxByte = replyEn ? i_BankRdData : '0;

    // phase, mode and index advance on each byte-completing edge
    always_ff @(posedge i_SPI_Clk or posedge asyncClear) begin
        if (asyncClear) begin
            phase   <= spiSensorPkg::phaseCmd;
            isRead  <= 1'b0;
            isWrite <= 1'b0;
            idx     <= '0;
        end else if (i_RxByteDone) begin
            case (phase)
                spiSensorPkg::phaseCmd: begin
                    isRead  <= cmdRead;
                    isWrite <= cmdWrite;
                    phase   <= (cmdRead || cmdWrite) ? spiSensorPkg::phaseAddr :
                                                       spiSensorPkg::phaseIgnore;
                end
                spiSensorPkg::phaseAddr: begin
                    idx   <= nextIdx;
                    phase <= spiSensorPkg::phaseData;
                end
                spiSensorPkg::phaseData: begin
                    idx <= nextIdx;
                end
                default: begin
                    // unknown opcode, wait for chip select
                    phase <= spiSensorPkg::phaseIgnore;
                end
            endcase
        end
    end

    // index never points past the bank
    idxInRange : assert property (
        @(posedge i_SPI_Clk) disable iff (reset)
        idx < `SAMPLE_IDX_W'(`SAMPLE_COUNT)
    ) else $error("bank index out of range");

    // a frame that writes the bank never serves a bank entry as reply
    wrNoReply : assert property (
        @(posedge i_SPI_Clk) disable iff (reset || i_SPI_CSLow)
        o_BankWrEn |-> (o_TxByte == '0)
    ) else $error("bank write in a frame that replies with data");

endmodule : frameDecoder

//--- source/sampleBank.sv
// five-entry register bank; index codes above the bank size read as zero and never write
`timescale 1ns/1ps
`include "spiSensor_consts.svh"

module sampleBank (
    input  logic                     i_SPI_Clk,
    input  logic                     reset,
    input  logic [`SAMPLE_IDX_W-1:0] i_RdIdx,
    input  logic                     i_WrEn,
    input  spiSensorPkg::spiByte_t    i_WrData,
    output spiSensorPkg::spiByte_t    o_RdData
);

    // sample storage
    spiSensorPkg::spiByte_t bank [`SAMPLE_COUNT];
    logic                   idxValid;

    // guards the unused index codes
    assign idxValid = (i_RdIdx < `SAMPLE_IDX_W'(`SAMPLE_COUNT));

    // combinational read so the decoder can pick a reply in the same cycle
    always_comb begin
        if (idxValid) begin
            o_RdData = bank[i_RdIdx];
        end else begin
            o_RdData = '0;
        end
    end

    // reset restores the sensor readings
    // write goes to the same index as the read port
    always_ff @(posedge i_SPI_Clk or posedge reset) begin
        if (reset) begin
            bank[0] <= `SAMPLE_INIT_0;
            bank[1] <= `SAMPLE_INIT_1;
            bank[2] <= `SAMPLE_INIT_2;
            bank[3] <= `SAMPLE_INIT_3;
            bank[4] <= `SAMPLE_INIT_4;
        end else if (i_WrEn && idxValid) begin
            bank[i_RdIdx] <= i_WrData;
        end
    end

    // a write to an unused index code would be lost
    wrIdxValid : assert property (
        @(posedge i_SPI_Clk) disable iff (reset)
        i_WrEn |-> idxValid
    ) else $error("bank write to an unused index");

endmodule : sampleBank

//--- source/spiTxShifter.sv
// MISO changes on the rising edge only; it is held at 0 while chip select is high
`timescale 1ns/1ps

module spiTxShifter (
    input  logic                  i_SPI_Clk,
    input  logic                  reset,
    input  logic                  i_SPI_CSLow,
    input  logic                  i_Load,
    input  spiSensorPkg::spiByte_t i_TxByte,
    output logic                  o_SPI_Miso
);

    // bits still to send after the one on MISO
    logic [6:0] txRest;
    logic       asyncClear;

    assign asyncClear = reset | i_SPI_CSLow;

    // load puts the MSB straight on MISO
    // the master samples it at the next falling edge
    always_ff @(posedge i_SPI_Clk or posedge asyncClear) begin
        if (asyncClear) begin
            o_SPI_Miso <= 1'b0;
            txRest     <= '0;
        end else if (i_Load) begin
            o_SPI_Miso <= i_TxByte[7];
            txRest     <= i_TxByte[6:0];
        end else begin
            // shift out, pad with zero
            o_SPI_Miso <= txRest[6];
            txRest     <= {txRest[5:0], 1'b0};
        end
    end

    // loads come once per byte, never on two edges in a row
    loadSpacing : assert property (
        @(posedge i_SPI_Clk) disable iff (reset || i_SPI_CSLow)
        i_Load |=> !i_Load
    ) else $error("MISO reloaded before the byte was sent");

endmodule : spiTxShifter

//--- source/spiSensorTop.sv
// SPI clock is the only clock; o_Rx_Byte updates on chip select rise, not on the SPI clock
`timescale 1ns/1ps

module spiSensorTop (
    input  logic                  i_SPI_Clk,
    input  logic                  reset,
    input  logic                  i_SPI_CSLow,
    input  logic                  i_SPI_Mosi,
    output logic                  o_SPI_Miso,
    output spiSensorPkg::spiByte_t o_Rx_Byte
);

    spiSensorPkg::spiByte_t rxByteNext;
    logic                   rxByteDone;
    spiSensorPkg::spiByte_t lastByte;
    logic [2:0]             bankIdx;
    logic                   bankWrEn;
    spiSensorPkg::spiByte_t bankWrData;
    spiSensorPkg::spiByte_t bankRdData;
    logic                   txLoad;
    spiSensorPkg::spiByte_t txByte;

    // MOSI side
    spiRxShifter u_spiRxShifter (
        .i_SPI_Clk    (i_SPI_Clk),
        .reset        (reset),
        .i_SPI_CSLow  (i_SPI_CSLow),
        .i_SPI_Mosi   (i_SPI_Mosi),
        .o_RxByteNext (rxByteNext),
        .o_RxByteDone (rxByteDone),
        .o_LastByte   (lastByte)
    );

    // frame control and bank addressing
    frameDecoder u_frameDecoder (
        .i_SPI_Clk    (i_SPI_Clk),
        .reset        (reset),
        .i_SPI_CSLow  (i_SPI_CSLow),
        .i_RxByte     (rxByteNext),
        .i_RxByteDone (rxByteDone),
        .i_BankRdData (bankRdData),
        .o_BankIdx    (bankIdx),
        .o_BankWrEn   (bankWrEn),
        .o_BankWrData (bankWrData),
        .o_TxLoad     (txLoad),
        .o_TxByte     (txByte)
    );

    sampleBank u_sampleBank (
        .i_SPI_Clk (i_SPI_Clk),
        .reset     (reset),
        .i_RdIdx   (bankIdx),
        .i_WrEn    (bankWrEn),
        .i_WrData  (bankWrData),
        .o_RdData  (bankRdData)
    );

    // MISO side
    spiTxShifter u_spiTxShifter (
        .i_SPI_Clk   (i_SPI_Clk),
        .reset       (reset),
        .i_SPI_CSLow (i_SPI_CSLow),
        .i_Load      (txLoad),
        .i_TxByte    (txByte),
        .o_SPI_Miso  (o_SPI_Miso)
    );

    // end of frame, keep the last complete byte
    always_ff @(posedge i_SPI_CSLow or posedge reset) begin
        if (reset) begin
            o_Rx_Byte <= '0;
        end else begin
            o_Rx_Byte <= lastByte;
        end
    end

endmodule : spiSensorTop

//--- sim/spiClockGen.sv
// free-running 100 ns clock from time 0; it never stops, so the testbench has to end the run
`timescale 1ns/1ps

module spiClockGen (
    output logic o_Clk
);

    // half of the 100 ns period
    localparam int halfPeriodNs = 50;

    // low at time 0, so the first rising edge is at 50 ns
    // and the first falling edge at 100 ns
    initial begin
        o_Clk = 1'b0;
        forever begin
            #(halfPeriodNs) o_Clk = ~o_Clk;
        end
    end

endmodule : spiClockGen

//--- sim/spiSensorTb.sv
// directed tests for the SPI sensor slave; inputs move on the falling edge, MISO is sampled there too
`timescale 1ns/1ps
`include "spiSensor_consts.svh"

module spiSensorTb;

    localparam int clkPeriodNs = 100;
    // bytes over all frames: 9 + 5 + 4 + 5 + 7 + 5 + 7 + 3 + 7
    localparam int frameBits = 8 * 52;
    // reset, gaps between frames and slack
    localparam int watchdogCycles = frameBits + 200;

    logic                   spiClk;
    logic                   reset;
    logic                   spiCsLow;
    logic                   spiMosi;
    logic                   spiMiso;
    spiSensorPkg::spiByte_t rxByte;

    // bytes to send, MISO bytes collected, expected replies
    spiSensorPkg::spiByte_t txQ[$];
    spiSensorPkg::spiByte_t rxQ[$];
    spiSensorPkg::spiByte_t expQ[$];
    // expected bank contents
    spiSensorPkg::spiByte_t model [`SAMPLE_COUNT];
    logic [31:0]            lfsrState;
    int                     checkCount = 0;
    int                     valueErrors = 0;
    int                     otherErrors = 0;

    spiClockGen u_spiClockGen (
        .o_Clk (spiClk)
    );

    spiSensorTop u_spiSensorTop (
        .i_SPI_Clk   (spiClk),
        .reset       (reset),
        .i_SPI_CSLow (spiCsLow),
        .i_SPI_Mosi  (spiMosi),
        .o_SPI_Miso  (spiMiso),
        .o_Rx_Byte   (rxByte)
    );

    // right-shifting Galois form, taps x^32 + x^30 + x^26 + x^25 + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hA300_0000;
        end
        return s >> 1;
    endfunction

    // one LFSR step per bit, MSB taken first
    task automatic randomByte(output spiSensorPkg::spiByte_t b);
        int i;
        b = '0;
        for (i = 0; i < 8; i++) begin
            b = {b[6:0], lfsrState[0]};
            lfsrState = lfsrStep(lfsrState);
        end
    endtask

    // start entry of a frame, out-of-range addresses go to 0
    function automatic int startIndex(input spiSensorPkg::spiByte_t addr);
        if (int'(addr) >= `SAMPLE_COUNT) begin
            return 0;
        end
        return int'(addr);
    endfunction

    // advance by one, last entry wraps to 0
    function automatic int nextIndex(input int i);
        return (i + 1) % `SAMPLE_COUNT;
    endfunction

    task automatic checkByte(input string name, input spiSensorPkg::spiByte_t got,
                             input spiSensorPkg::spiByte_t exp);
        checkCount++;
        if (got !== exp) begin
            valueErrors++;
            $display("[FAIL] %s got 0x%02h expected 0x%02h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        checkCount++;
        if (got !== exp) begin
            valueErrors++;
            $display("[FAIL] %s got 0x%1h expected 0x%1h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic startFrame(input spiSensorPkg::spiByte_t cmd,
                              input spiSensorPkg::spiByte_t addr);
        txQ.delete();
        txQ.push_back(cmd);
        txQ.push_back(addr);
    endtask

    task automatic addRandomData(input int count);
        spiSensorPkg::spiByte_t b;
        int n;
        for (n = 0; n < count; n++) begin
            randomByte(b);
            txQ.push_back(b);
        end
    endtask

    // bit-bang txQ, stop after bitLimit bits, collect complete MISO bytes into rxQ
    task automatic shiftFrame(input int bitLimit);
        spiSensorPkg::spiByte_t outByte;
        spiSensorPkg::spiByte_t inByte;
        int sent;
        int b;
        int k;
        rxQ.delete();
        sent = 0;
        for (b = 0; b < txQ.size() && sent < bitLimit; b++) begin
            outByte = txQ[b];
            inByte  = '0;
            for (k = 0; k < 8 && sent < bitLimit; k++) begin
                @(negedge spiClk);
                spiCsLow = 1'b0;
                // MISO was set on the last rising edge
                inByte  = {inByte[6:0], spiMiso};
                spiMosi = outByte[7];
                outByte = outByte << 1;
                sent++;
            end
            if (sent == (b + 1) * 8) begin
                rxQ.push_back(inByte);
            end
        end
        @(negedge spiClk);
        spiCsLow = 1'b1;
        spiMosi  = 1'b0;
        // o_Rx_Byte has settled by the next falling edge
        @(negedge spiClk);
        checkBit("o_SPI_Miso", spiMiso, 1'b0);
    endtask

    // no reply is due during the command and address bytes
    task automatic checkHeaderReplies();
        if (rxQ.size() < 2) begin
            otherErrors++;
            $display("frame returned fewer than two complete bytes");
        end else begin
            checkByte("o_SPI_Miso command byte", rxQ[0], 8'h00);
            checkByte("o_SPI_Miso address byte", rxQ[1], 8'h00);
        end
    endtask

    task automatic compareReplies(input int first);
        int n;
        if (rxQ.size() != first + expQ.size()) begin
            otherErrors++;
            $display("frame returned %0d bytes where %0d were expected",
                     rxQ.size(), first + expQ.size());
        end else begin
            for (n = 0; n < expQ.size(); n++) begin
                checkByte($sformatf("o_SPI_Miso data byte %0d", n), rxQ[first + n], expQ[n]);
            end
        end
    endtask

    // read frame checked against the model
    task automatic readAndCompare(input spiSensorPkg::spiByte_t addr, input int count);
        int idx;
        int n;
        startFrame(`SPI_CMD_READ, addr);
        addRandomData(count);
        shiftFrame(txQ.size() * 8);
        expQ.delete();
        idx = startIndex(addr);
        for (n = 0; n < count; n++) begin
            expQ.push_back(model[idx]);
            idx = nextIndex(idx);
        end
        checkHeaderReplies();
        compareReplies(2);
        checkByte("o_Rx_Byte", rxByte, txQ[txQ.size() - 1]);
    endtask

    task automatic testResetState();
        checkBit("o_SPI_Miso", spiMiso, 1'b0);
        checkByte("o_Rx_Byte", rxByte, 8'h00);
    endtask

    // reference values straight from the sensor table, with wrap after entry 4
    task automatic testReadFromZero();
        startFrame(`SPI_CMD_READ, 8'h00);
        addRandomData(7);
        shiftFrame(txQ.size() * 8);
        expQ.delete();
        expQ.push_back(8'hFF);
        expQ.push_back(8'h06);
        expQ.push_back(8'hFD);
        expQ.push_back(8'h02);
        expQ.push_back(8'h24);
        expQ.push_back(8'hFF);
        expQ.push_back(8'h06);
        checkHeaderReplies();
        compareReplies(2);
        checkByte("o_Rx_Byte", rxByte, txQ[txQ.size() - 1]);
    endtask

    task automatic testReadOffsets();
        readAndCompare(8'h03, 3);
        // address 6 is out of range
        readAndCompare(8'h06, 2);
    endtask

    task automatic testWriteWrap();
        int idx;
        int n;
        startFrame(`SPI_CMD_WRITE, 8'h04);
        addRandomData(3);
        shiftFrame(txQ.size() * 8);
        // write frames reply with zeros
        expQ.delete();
        for (n = 0; n < 3; n++) begin
            expQ.push_back(8'h00);
        end
        checkHeaderReplies();
        compareReplies(2);
        checkByte("o_Rx_Byte", rxByte, txQ[txQ.size() - 1]);
        // entries 4, 0 and 1
        idx = startIndex(8'h04);
        for (n = 0; n < 3; n++) begin
            model[idx] = txQ[2 + n];
            idx = nextIndex(idx);
        end
        readAndCompare(8'h00, 5);
    endtask

    task automatic testUnknownOpcode();
        int n;
        startFrame(8'h5A, 8'h01);
        addRandomData(3);
        shiftFrame(txQ.size() * 8);
        expQ.delete();
        for (n = 0; n < 3; n++) begin
            expQ.push_back(8'h00);
        end
        checkHeaderReplies();
        compareReplies(2);
        checkByte("o_Rx_Byte", rxByte, txQ[txQ.size() - 1]);
        // bank must be untouched
        readAndCompare(8'h00, 5);
    endtask

    // chip select rises after 4 bits of the first data byte
    task automatic testCutFrame();
        startFrame(`SPI_CMD_WRITE, 8'h02);
        addRandomData(1);
        shiftFrame(20);
        checkHeaderReplies();
        checkByte("o_Rx_Byte", rxByte, txQ[1]);
        readAndCompare(8'h00, 5);
    endtask

    task automatic finishRun();
        $display("checks: %0d, value errors: %0d, other errors: %0d",
                 checkCount, valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    initial begin
        reset    = 1'b0;
        spiCsLow = 1'b1;
        spiMosi  = 1'b0;
        lfsrState = 32'hefad_0d87;
        model[0] = `SAMPLE_INIT_0;
        model[1] = `SAMPLE_INIT_1;
        model[2] = `SAMPLE_INIT_2;
        model[3] = `SAMPLE_INIT_3;
        model[4] = `SAMPLE_INIT_4;
        // a real rising edge on reset
        #1;
        reset = 1'b1;
        repeat (10) @(negedge spiClk);
        reset = 1'b0;
        @(negedge spiClk);
        testResetState();
        testReadFromZero();
        testReadOffsets();
        testWriteWrap();
        testUnknownOpcode();
        testCutFrame();
        finishRun();
    end

    // watchdog sized from the frame lengths
    initial begin
        #(watchdogCycles * clkPeriodNs);
        otherErrors++;
        $display("timeout: the tests did not finish within %0d clock cycles", watchdogCycles);
        finishRun();
    end

endmodule : spiSensorTb

//--- all.f
+incdir+source
source/spiSensorPkg.sv
source/spiRxShifter.sv
source/frameDecoder.sv
source/sampleBank.sv
source/spiTxShifter.sv
source/spiSensorTop.sv
sim/spiClockGen.sv
sim/spiSensorTb.sv

//--- run.sh
#!/bin/sh
# compile and run the SPI sensor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module spiSensorTb -f all.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit 1
fi

output=$(./obj_dir/VspiSensorTb)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# pass only if the exact pass line was printed
if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
    exit 0
else
    exit 1
fi
